// File: src/sopc_pkg.sv
package sopc_pkg;

	// bus targets behind the wishbone slave port
	typedef enum logic [2:0] {
		TGT_BASERAM,
		TGT_EXTRAM,
		TGT_TIMER,
		TGT_SEG,
		TGT_NONE
	} target_t;

	// address bits 31..28 for each target
	localparam logic [3:0] TGT_BASE_BASERAM = 4'h0;
	localparam logic [3:0] TGT_BASE_EXTRAM  = 4'h1;
	localparam logic [3:0] TGT_BASE_TIMER   = 4'h2;
	localparam logic [3:0] TGT_BASE_SEG     = 4'h3;

	// sram word address width for 1M words per bank
	localparam int SRAM_AW = 20;

	// cycles oe_n or we_n stays low per access
	localparam int SRAM_WAIT = 2;

	// sram controller states
	typedef enum logic [1:0] {
		ST_IDLE,
		ST_RD,
		ST_WR,
		ST_DONE
	} sram_state_t;

	// timer register byte offsets
	localparam logic [3:0] TMR_COUNT   = 4'h0;
	localparam logic [3:0] TMR_COMPARE = 4'h4;
	localparam logic [3:0] TMR_CTRL    = 4'h8;

	// timer ctrl bits
	localparam int TMR_CTRL_EN  = 0;
	localparam int TMR_CTRL_PND = 1;

endpackage

// File: src/wb_bus_decode.sv
`timescale 1ns/1ps

module wb_bus_decode (
	input  logic        clk,
	input  logic        rst_n_i,
	input  logic        wb_cyc_i,
	input  logic        wb_stb_i,
	input  logic [31:0] wb_addr_i,
	output logic [31:0] wb_data_o,
	output logic        wb_ack_o,
	output logic        sram_stb_o,
	output logic        bank_sel_o,
	output logic        tmr_stb_o,
	output logic        seg_stb_o,
	input  logic        sram_ack_i,
	input  logic [31:0] sram_data_i,
	input  logic        tmr_ack_i,
	input  logic [31:0] tmr_data_i,
	input  logic        seg_ack_i,
	input  logic [31:0] seg_data_i
);
	import sopc_pkg::*;

	target_t tgt;
	logic    req;
	logic    none_ack;

	always_comb begin
		case (wb_addr_i[31:28])
			TGT_BASE_BASERAM: tgt = TGT_BASERAM;
			TGT_BASE_EXTRAM:  tgt = TGT_EXTRAM;
			TGT_BASE_TIMER:   tgt = TGT_TIMER;
			TGT_BASE_SEG:     tgt = TGT_SEG;
			default:          tgt = TGT_NONE;
		endcase
	end

	assign req        = wb_cyc_i & wb_stb_i;
	assign sram_stb_o = req & ((tgt == TGT_BASERAM) | (tgt == TGT_EXTRAM));
	assign bank_sel_o = (tgt == TGT_EXTRAM);
	assign tmr_stb_o  = req & (tgt == TGT_TIMER);
	assign seg_stb_o  = req & (tgt == TGT_SEG);

	// unmapped space answers itself
	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			none_ack <= 1'b0;
		end else begin
			none_ack <= req & (tgt == TGT_NONE) & ~none_ack;
		end
	end

	always_comb begin
		case (tgt)
			TGT_BASERAM, TGT_EXTRAM: wb_data_o = sram_data_i;
			TGT_TIMER:               wb_data_o = tmr_data_i;
			TGT_SEG:                 wb_data_o = seg_data_i;
			default:                 wb_data_o = 32'h0;
		endcase
	end

	assign wb_ack_o = sram_ack_i | tmr_ack_i | seg_ack_i | none_ack;

	// every ack answers a request seen on the previous edge
	a_ack_has_req: assert property (@(posedge clk) disable iff (!rst_n_i)
		wb_ack_o |-> $past(wb_cyc_i && wb_stb_i));

endmodule

// File: src/sram_ctrl_fsm.sv
`timescale 1ns/1ps

module sram_ctrl_fsm (
	input  logic                  clk,
	input  logic                  rst_n_i,
	input  logic                  stb_i,
	input  logic                  we_i,
	input  logic [3:0]            sel_i,
	input  logic                  bank_sel_i,
	output sopc_pkg::sram_state_t state_o,
	output logic                  base_ce_n_o,
	output logic                  ext_ce_n_o,
	output logic                  oe_n_o,
	output logic                  we_n_o,
	output logic                  data_oe_o,
	output logic                  ack_o
);
	import sopc_pkg::*;

	localparam int CNT_W = (SRAM_WAIT > 1) ? $clog2(SRAM_WAIT) : 1;

	sram_state_t      state_q;
	sram_state_t      state_d;
	logic [CNT_W-1:0] wait_cnt;
	logic             wait_last;
	logic             active;

	assign wait_last = (wait_cnt == CNT_W'(SRAM_WAIT - 1));

	always_comb begin
		state_d = state_q;
		case (state_q)
			ST_IDLE: begin
				// full-word write needs no old data
				if (stb_i) begin
					state_d = (we_i && sel_i == 4'hf) ? ST_WR : ST_RD;
				end
			end
			ST_RD: begin
				if (wait_last) begin
					state_d = we_i ? ST_WR : ST_DONE;
				end
			end
			ST_WR: begin
				if (wait_last) begin
					state_d = ST_DONE;
				end
			end
			default: begin
				state_d = ST_IDLE;
			end
		endcase
	end

	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			state_q  <= ST_IDLE;
			wait_cnt <= '0;
		end else begin
			state_q <= state_d;
			if (state_d != state_q) begin
				wait_cnt <= '0;
			end else if (active) begin
				wait_cnt <= wait_cnt + 1'b1;
			end
		end
	end

	assign active      = (state_q == ST_RD) || (state_q == ST_WR);
	assign state_o     = state_q;
	assign base_ce_n_o = ~(active & ~bank_sel_i);
	assign ext_ce_n_o  = ~(active & bank_sel_i);
	assign oe_n_o      = ~(state_q == ST_RD);
	assign we_n_o      = ~(state_q == ST_WR);
	assign data_oe_o   = (state_q == ST_WR);
	assign ack_o       = (state_q == ST_DONE);

	a_no_oe_we: assert property (@(posedge clk) disable iff (!rst_n_i)
		!(!oe_n_o && !we_n_o));
	a_one_bank: assert property (@(posedge clk) disable iff (!rst_n_i)
		!(!base_ce_n_o && !ext_ce_n_o));

endmodule

// File: src/sram_datapath.sv
`timescale 1ns/1ps

module sram_datapath (
	input  logic                  clk,
	input  logic                  rst_n_i,
	input  sopc_pkg::sram_state_t state_i,
	input  logic [3:0]            sel_i,
	input  logic                  bank_sel_i,
	input  logic [31:0]           wb_data_i,
	input  logic [31:0]           base_data_i,
	input  logic [31:0]           ext_data_i,
	output logic [31:0]           sram_data_o,
	output logic [31:0]           rd_data_o
);
	import sopc_pkg::*;

	logic [31:0] bank_data;
	logic [31:0] rd_q;
	logic [31:0] merged;

	assign bank_data = bank_sel_i ? ext_data_i : base_data_i;

	// last cycle of the read phase wins
	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			rd_q <= 32'h0;
		end else if (state_i == ST_RD) begin
			rd_q <= bank_data;
		end
	end

	// byte lane merge for read-modify-write
	always_comb begin
		for (int i = 0; i < 4; i++) begin
			merged[i*8 +: 8] = sel_i[i] ? wb_data_i[i*8 +: 8] : rd_q[i*8 +: 8];
		end
	end

	// keep the bus quiet outside the write phase
	assign sram_data_o = (state_i == ST_WR) ? merged : 32'h0;
	assign rd_data_o   = rd_q;

endmodule

// File: src/timer_unit.sv
`timescale 1ns/1ps

module timer_unit (
	input  logic        clk,
	input  logic        rst_n_i,
	input  logic        stb_i,
	input  logic        we_i,
	input  logic [1:0]  addr_i,
	input  logic [31:0] data_i,
	output logic [31:0] data_o,
	output logic        ack_o,
	output logic        timer_int_o
);
	import sopc_pkg::*;

	logic [31:0] count;
	logic [31:0] compare;
	logic        enable;
	logic        pending;
	logic        access;
	logic [3:0]  offset;

	assign access = stb_i & ~ack_o;
	assign offset = {addr_i, 2'b00};

	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			count   <= 32'h0;
			compare <= 32'h0;
			enable  <= 1'b0;
			pending <= 1'b0;
			ack_o   <= 1'b0;
		end else begin
			ack_o <= access;
			if (access && we_i && offset == TMR_COUNT) begin
				count <= data_i;
			end else if (enable) begin
				count <= count + 32'd1;
			end
			if (access && we_i && offset == TMR_COMPARE) begin
				compare <= data_i;
			end
			if (access && we_i && offset == TMR_CTRL) begin
				enable <= data_i[TMR_CTRL_EN];
			end
			// software clear beats a new match
			if (access && we_i && offset == TMR_CTRL && data_i[TMR_CTRL_PND]) begin
				pending <= 1'b0;
			end else if (enable && count == compare) begin
				pending <= 1'b1;
			end
		end
	end

	always_comb begin
		case (offset)
			TMR_COUNT:   data_o = count;
			TMR_COMPARE: data_o = compare;
			TMR_CTRL:    data_o = {30'h0, pending, enable};
			default:     data_o = 32'h0;
		endcase
	end

	assign timer_int_o = pending;

	a_ack_pulse: assert property (@(posedge clk) disable iff (!rst_n_i)
		ack_o |=> !ack_o);

endmodule

// File: src/segdisp_unit.sv
`timescale 1ns/1ps

module segdisp_unit (
	input  logic        clk,
	input  logic        rst_n_i,
	input  logic        stb_i,
	input  logic        we_i,
	input  logic [31:0] data_i,
	output logic [31:0] data_o,
	output logic        ack_o,
	output logic [6:0]  seg0_o,
	output logic [6:0]  seg1_o
);

	logic [7:0] disp_q;

	// bit 0 is segment a, bit 6 is g
	function automatic logic [6:0] hex_glyph(input logic [3:0] nib);
		case (nib)
			4'h0: hex_glyph = 7'h3f;
			4'h1: hex_glyph = 7'h06;
			4'h2: hex_glyph = 7'h5b;
			4'h3: hex_glyph = 7'h4f;
			4'h4: hex_glyph = 7'h66;
			4'h5: hex_glyph = 7'h6d;
			4'h6: hex_glyph = 7'h7d;
			4'h7: hex_glyph = 7'h07;
			4'h8: hex_glyph = 7'h7f;
			4'h9: hex_glyph = 7'h6f;
			4'ha: hex_glyph = 7'h77;
			4'hb: hex_glyph = 7'h7c;
			4'hc: hex_glyph = 7'h39;
			4'hd: hex_glyph = 7'h5e;
			4'he: hex_glyph = 7'h79;
			default: hex_glyph = 7'h71;
		endcase
	endfunction

	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			disp_q <= 8'h00;
			ack_o  <= 1'b0;
		end else begin
			ack_o <= stb_i & ~ack_o;
			if (stb_i && !ack_o && we_i) begin
				disp_q <= data_i[7:0];
			end
		end
	end

	assign data_o = {24'h0, disp_q};
	assign seg0_o = hex_glyph(disp_q[3:0]);
	assign seg1_o = hex_glyph(disp_q[7:4]);

endmodule

// File: src/sopc_bus.sv
`timescale 1ns/1ps

module sopc_bus (
	input  logic                         clk,
	input  logic                         rst_n_i,
	input  logic                         wb_cyc_i,
	input  logic                         wb_stb_i,
	input  logic                         wb_we_i,
	input  logic [31:0]                  wb_addr_i,
	input  logic [3:0]                   wb_sel_i,
	input  logic [31:0]                  wb_data_i,
	output logic [31:0]                  wb_data_o,
	output logic                         wb_ack_o,
	output logic [sopc_pkg::SRAM_AW-1:0] baseram_addr_o,
	output logic [31:0]                  baseram_data_o,
	output logic                         baseram_data_oe_o,
	input  logic [31:0]                  baseram_data_i,
	output logic                         baseram_ce_n_o,
	output logic                         baseram_oe_n_o,
	output logic                         baseram_we_n_o,
	output logic [sopc_pkg::SRAM_AW-1:0] extram_addr_o,
	output logic [31:0]                  extram_data_o,
	output logic                         extram_data_oe_o,
	input  logic [31:0]                  extram_data_i,
	output logic                         extram_ce_n_o,
	output logic                         extram_oe_n_o,
	output logic                         extram_we_n_o,
	output logic                         timer_int_o,
	output logic [6:0]                   segdisp0_o,
	output logic [6:0]                   segdisp1_o
);
	import sopc_pkg::*;

	logic        sram_stb, sram_ack, bank_sel;
	logic        tmr_stb, tmr_ack, seg_stb, seg_ack;
	logic [31:0] sram_rd_data, sram_wr_data, tmr_data, seg_data;
	logic        oe_n, we_n, data_oe;
	sram_state_t sram_state;

	// both banks share address, write data and strobes
	assign baseram_addr_o    = wb_addr_i[SRAM_AW+1:2];
	assign extram_addr_o     = wb_addr_i[SRAM_AW+1:2];
	assign baseram_data_o    = sram_wr_data;
	assign extram_data_o     = sram_wr_data;
	assign baseram_oe_n_o    = oe_n;
	assign extram_oe_n_o     = oe_n;
	assign baseram_we_n_o    = we_n;
	assign extram_we_n_o     = we_n;
	assign baseram_data_oe_o = data_oe & ~bank_sel;
	assign extram_data_oe_o  = data_oe & bank_sel;

	wb_bus_decode u_decode (.clk(clk), .rst_n_i(rst_n_i), .wb_cyc_i(wb_cyc_i),
		.wb_stb_i(wb_stb_i), .wb_addr_i(wb_addr_i), .wb_data_o(wb_data_o),
		.wb_ack_o(wb_ack_o), .sram_stb_o(sram_stb), .bank_sel_o(bank_sel),
		.tmr_stb_o(tmr_stb), .seg_stb_o(seg_stb), .sram_ack_i(sram_ack),
		.sram_data_i(sram_rd_data), .tmr_ack_i(tmr_ack), .tmr_data_i(tmr_data),
		.seg_ack_i(seg_ack), .seg_data_i(seg_data));

	sram_ctrl_fsm u_sram_fsm (.clk(clk), .rst_n_i(rst_n_i), .stb_i(sram_stb),
		.we_i(wb_we_i), .sel_i(wb_sel_i), .bank_sel_i(bank_sel), .state_o(sram_state),
		.base_ce_n_o(baseram_ce_n_o), .ext_ce_n_o(extram_ce_n_o), .oe_n_o(oe_n),
		.we_n_o(we_n), .data_oe_o(data_oe), .ack_o(sram_ack));

	sram_datapath u_sram_dp (.clk(clk), .rst_n_i(rst_n_i), .state_i(sram_state),
		.sel_i(wb_sel_i), .bank_sel_i(bank_sel), .wb_data_i(wb_data_i),
		.base_data_i(baseram_data_i), .ext_data_i(extram_data_i),
		.sram_data_o(sram_wr_data), .rd_data_o(sram_rd_data));

	timer_unit u_timer (.clk(clk), .rst_n_i(rst_n_i), .stb_i(tmr_stb), .we_i(wb_we_i),
		.addr_i(wb_addr_i[3:2]), .data_i(wb_data_i), .data_o(tmr_data),
		.ack_o(tmr_ack), .timer_int_o(timer_int_o));

	segdisp_unit u_segdisp (.clk(clk), .rst_n_i(rst_n_i), .stb_i(seg_stb),
		.we_i(wb_we_i), .data_i(wb_data_i), .data_o(seg_data), .ack_o(seg_ack),
		.seg0_o(segdisp0_o), .seg1_o(segdisp1_o));

endmodule

// File: testbench/sram_model.sv
`timescale 1ns/1ps

module sram_model #(
	parameter logic [31:0] FILL_KEY = 32'h0
) (
	input  logic [19:0] addr_i,
	input  logic [31:0] data_i,
	input  logic        data_oe_i,
	output logic [31:0] data_o,
	input  logic        ce_n_i,
	input  logic        oe_n_i,
	input  logic        we_n_i
);

	logic [31:0] mem [0:(1<<20)-1];
	logic [20:0] a;

	// each word starts from its own address
	initial begin
		for (a = 21'h0; a < 21'h100000; a++) begin
			mem[a[19:0]] = {a[11:0], a[19:0]} ^ FILL_KEY;
		end
	end

	// write lands mid-pulse once address and data have settled
	always @(negedge we_n_i) begin
		#5;
		if (!ce_n_i && !we_n_i && data_oe_i) begin
			mem[addr_i] = data_i;
		end
	end

	// a floating bus reads as zero
	assign data_o = (!ce_n_i && !oe_n_i) ? mem[addr_i] : 32'h0;

endmodule

// File: testbench/tb_sopc_bus.sv
`timescale 1ns/1ps

module tb_sopc_bus;
	localparam int NUM_TESTS = 6;
	localparam int WATCHDOG_CYCLES = 2000 * NUM_TESTS;
	localparam int ACK_LIMIT = 50;
	localparam logic [31:0] BASE_FILL = 32'h5a00_0000;
	localparam logic [31:0] EXT_FILL = 32'hc300_0000;
	localparam logic [31:0] TMR_BASE = 32'h2000_0000;
	localparam logic [31:0] SEG_BASE = 32'h3000_0000;
	// gfedcba glyphs for 0..f
	localparam logic [6:0] GLYPHS [16] = '{7'h3f, 7'h06, 7'h5b, 7'h4f, 7'h66, 7'h6d, 7'h7d,
		7'h07, 7'h7f, 7'h6f, 7'h77, 7'h7c, 7'h39, 7'h5e, 7'h79, 7'h71};

	logic        clk, rst_n_i, wb_cyc_i, wb_stb_i, wb_we_i, wb_ack_o;
	logic [31:0] wb_addr_i, wb_data_i, wb_data_o;
	logic [3:0]  wb_sel_i;
	logic [19:0] baseram_addr_o, extram_addr_o;
	logic [31:0] baseram_data_o, baseram_data_i, extram_data_o, extram_data_i;
	logic        baseram_data_oe_o, baseram_ce_n_o, baseram_oe_n_o, baseram_we_n_o;
	logic        extram_data_oe_o, extram_ce_n_o, extram_oe_n_o, extram_we_n_o;
	logic        timer_int_o;
	logic [6:0]  segdisp0_o, segdisp1_o;
	logic [31:0] shadow [logic [20:0]];
	integer      seed;
	int          errors;

	sopc_bus uut (.*);

	sram_model #(.FILL_KEY(BASE_FILL)) u_baseram (.addr_i(baseram_addr_o),
		.data_i(baseram_data_o), .data_oe_i(baseram_data_oe_o), .data_o(baseram_data_i),
		.ce_n_i(baseram_ce_n_o), .oe_n_i(baseram_oe_n_o), .we_n_i(baseram_we_n_o));
	sram_model #(.FILL_KEY(EXT_FILL)) u_extram (.addr_i(extram_addr_o),
		.data_i(extram_data_o), .data_oe_i(extram_data_oe_o), .data_o(extram_data_i),
		.ce_n_i(extram_ce_n_o), .oe_n_i(extram_oe_n_o), .we_n_i(extram_we_n_o));

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		$display("watchdog expired after %0d cycles, tests did not finish", WATCHDOG_CYCLES);
		$display("SIMULATION FAILED");
		$finish;
	end

	function automatic logic [31:0] expected_word(input logic bank, input logic [19:0] waddr);
		if (shadow.exists({bank, waddr})) begin
			return shadow[{bank, waddr}];
		end
		return {waddr[11:0], waddr} ^ (bank ? EXT_FILL : BASE_FILL);
	endfunction

	function automatic logic [31:0] sram_addr(input logic bank, input logic [19:0] waddr);
		return {3'b000, bank, 6'h00, waddr, 2'b00};
	endfunction

	task automatic check_value(input string what, input logic [31:0] got,
		input logic [31:0] exp);
		assert (got == exp) else begin
			errors++;
			$display("[FAIL] %0t ns: %s got %h expected %h", $time, what, got, exp);
		end
	endtask

	task automatic wb_cycle(input logic we, input logic [31:0] addr, input logic [3:0] sel,
		input logic [31:0] wdata, output logic [31:0] rdata);
		int waited;
		waited = 0;
		@(negedge clk);
		wb_cyc_i = 1'b1;
		wb_stb_i = 1'b1;
		wb_we_i = we;
		wb_addr_i = addr;
		wb_sel_i = sel;
		wb_data_i = wdata;
		do begin
			@(negedge clk);
			waited++;
		end while (!wb_ack_o && waited < ACK_LIMIT);
		if (!wb_ack_o) begin
			errors++;
			$display("no ack from address %h within %0d cycles", addr, ACK_LIMIT);
		end
		rdata = wb_data_o;
		wb_cyc_i = 1'b0;
		wb_stb_i = 1'b0;
		wb_we_i = 1'b0;
	endtask

	task automatic wb_write(input logic [31:0] addr, input logic [3:0] sel,
		input logic [31:0] data);
		logic [31:0] unused;
		wb_cycle(1'b1, addr, sel, data, unused);
	endtask

	task automatic wb_read(input logic [31:0] addr, output logic [31:0] data);
		wb_cycle(1'b0, addr, 4'hf, 32'h0, data);
	endtask

	task automatic sram_write(input logic bank, input logic [19:0] waddr,
		input logic [3:0] sel, input logic [31:0] data);
		logic [31:0] word;
		word = expected_word(bank, waddr);
		// only the selected lanes change
		for (int i = 0; i < 4; i++) begin
			if (sel[i]) begin
				word[i*8 +: 8] = data[i*8 +: 8];
			end
		end
		wb_write(sram_addr(bank, waddr), sel, data);
		shadow[{bank, waddr}] = word;
	endtask

	task automatic sram_check(input logic bank, input logic [19:0] waddr);
		logic [31:0] got;
		wb_read(sram_addr(bank, waddr), got);
		check_value($sformatf("bank %0d word %h", bank, waddr), got, expected_word(bank, waddr));
	endtask

	task automatic check_reset_state();
		check_value("ack after reset", {31'h0, wb_ack_o}, 32'h0);
		check_value("sram controls after reset", {26'h0, baseram_ce_n_o, baseram_oe_n_o,
			baseram_we_n_o, extram_ce_n_o, extram_oe_n_o, extram_we_n_o}, 32'h3f);
		check_value("data enables after reset", {30'h0, baseram_data_oe_o, extram_data_oe_o},
			32'h0);
		check_value("irq after reset", {31'h0, timer_int_o}, 32'h0);
		check_value("segments after reset", {18'h0, segdisp1_o, segdisp0_o},
			{18'h0, GLYPHS[0], GLYPHS[0]});
	endtask

	task automatic test_full_words();
		logic [19:0] waddr;
		for (int i = 0; i < 6; i++) begin
			waddr = 20'(i * 4099 + 7);
			sram_write(1'b0, waddr, 4'hf, $random(seed));
			sram_write(1'b1, waddr, 4'hf, $random(seed));
		end
		for (int i = 0; i < 6; i++) begin
			sram_check(1'b0, 20'(i * 4099 + 7));
			sram_check(1'b1, 20'(i * 4099 + 7));
		end
		// extram keeps its own word at the same offset
		sram_write(1'b0, 20'hfffff, 4'hf, 32'hdead_beef);
		sram_check(1'b0, 20'hfffff);
		sram_check(1'b1, 20'hfffff);
	endtask

	task automatic test_partial_writes();
		logic [3:0] lanes [5] = '{4'h1, 4'h2, 4'h4, 4'h8, 4'h6};
		for (int b = 0; b < 2; b++) begin
			sram_write(1'(b), 20'h00042, 4'hf, 32'h1122_3344);
			foreach (lanes[i]) begin
				sram_write(1'(b), 20'h00042, lanes[i], $random(seed));
				sram_check(1'(b), 20'h00042);
			end
		end
	endtask

	task automatic test_timer();
		logic [31:0] got;
		int cycles;
		wb_write(TMR_BASE + 32'h4, 4'hf, 32'd50);
		wb_write(TMR_BASE, 4'hf, 32'd0);
		wb_write(TMR_BASE + 32'h8, 4'hf, 32'h1);
		cycles = 0;
		while (!timer_int_o && cycles < 60) begin
			@(negedge clk);
			cycles++;
		end
		assert (timer_int_o && cycles >= 40) else begin
			errors++;
			$display("[FAIL] %0t ns: timer irq state %b after %0d cycles, expected 40 to 60",
				$time, timer_int_o, cycles);
		end
		wb_read(TMR_BASE + 32'h8, got);
		check_value("timer ctrl pending", got, 32'h3);
		wb_write(TMR_BASE + 32'h8, 4'hf, 32'h2);
		check_value("timer irq after clear", {31'h0, timer_int_o}, 32'h0);
		wb_read(TMR_BASE + 32'h8, got);
		check_value("timer ctrl after clear", got, 32'h0);
	endtask

	task automatic test_display();
		logic [31:0] got;
		logic [7:0] val;
		for (int i = 0; i <= 16; i++) begin
			val = (i == 16) ? 8'h5a : 8'(i * 17);
			wb_write(SEG_BASE, 4'hf, {24'h0, val});
			check_value("seg digit 0", {25'h0, segdisp0_o}, {25'h0, GLYPHS[val[3:0]]});
			check_value("seg digit 1", {25'h0, segdisp1_o}, {25'h0, GLYPHS[val[7:4]]});
			wb_read(SEG_BASE, got);
			check_value("seg readback", got, {24'h0, val});
		end
	endtask

	task automatic test_unmapped();
		logic [31:0] got;
		wb_read(32'h7000_0000, got);
		check_value("unmapped read", got, 32'h0);
		sram_write(1'b1, 20'h00abc, 4'hf, 32'h0bad_cafe);
		sram_check(1'b1, 20'h00abc);
	endtask

	task automatic test_random();
		logic [31:0] r;
		// small window so reads hit earlier writes
		for (int n = 0; n < 200; n++) begin
			r = $random(seed);
			if (r[0]) begin
				sram_write(r[1], {14'h0, r[7:2]}, r[11:8], $random(seed));
			end else begin
				sram_check(r[1], {14'h0, r[7:2]});
			end
		end
	endtask

	initial begin
		errors = 0;
		seed = 32'h0396f651;
		rst_n_i = 1'b0;
		wb_cyc_i = 1'b0;
		wb_stb_i = 1'b0;
		wb_we_i = 1'b0;
		wb_addr_i = 32'h0;
		wb_sel_i = 4'h0;
		wb_data_i = 32'h0;
		repeat (5) @(posedge clk);
		@(negedge clk);
		rst_n_i = 1'b1;
		check_reset_state();
		test_full_words();
		test_partial_writes();
		test_timer();
		test_display();
		test_unmapped();
		test_random();
		$display("tests done, %0d errors", errors);
		if (errors == 0) begin
			$display("SIMULATION PASSED");
		end else begin
			$display("SIMULATION FAILED");
		end
		$finish;
	end

endmodule

// File: mini_sopc.f
src/sopc_pkg.sv
src/wb_bus_decode.sv
src/sram_ctrl_fsm.sv
src/sram_datapath.sv
src/timer_unit.sv
src/segdisp_unit.sv
src/sopc_bus.sv
testbench/sram_model.sv
testbench/tb_sopc_bus.sv

// File: Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert --top-module tb_sopc_bus -f mini_sopc.f
	@out=$$(./obj_dir/Vtb_sopc_bus); echo "$$out"; \
	echo "$$out" | grep -q "SIMULATION PASSED"

clean:
	rm -rf obj_dir
